/* elastic_buffer_macros.svh */
`ifndef ELASTIC_BUFFER_MACROS_SVH
`define ELASTIC_BUFFER_MACROS_SVH

// line symbol width, one 10b code group
`define EB_DATA_WIDTH 10

// storage entries and pointer width without the wrap bit
`define EB_DEPTH 16
`define EB_ADDR_WIDTH 4

// SKP code group in both running disparities
`define EB_SKP_RDN 10'b0011111001
`define EB_SKP_RDP 10'b1100000110

// half-full mode, level kept between these two
`define EB_HF_HIGH 10
`define EB_HF_LOW 6

// nominal-empty mode, only removal is active
`define EB_NE_HIGH 3

`endif

/* elastic_buffer_pkg.sv */
`include "elastic_buffer_macros.svh"

package elastic_buffer_pkg;

  // operating point of the buffer
  typedef enum logic [0:0] {
    HALF_FULL     = 1'b0,
    NOMINAL_EMPTY = 1'b1
  } buffer_mode_e;

  // APB register map, byte addresses
  typedef enum logic [7:0] {
    REG_CTRL         = 8'h00,
    REG_STATUS       = 8'h04,
    REG_SKP_REMOVED  = 8'h08,
    REG_OVERFLOW_CNT = 8'h0C
  } reg_addr_e;

  // gray to binary, pointer width including the wrap bit
  function automatic logic [`EB_ADDR_WIDTH:0] gray_to_bin(input logic [`EB_ADDR_WIDTH:0] gray);
    logic [`EB_ADDR_WIDTH:0] bin;
    bin[`EB_ADDR_WIDTH] = gray[`EB_ADDR_WIDTH];
    // each bit is the xor of all gray bits above and itself
    for (int i = `EB_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* write_pointer_control.sv */
`timescale 1ns/1ps
`include "elastic_buffer_macros.svh"

module write_pointer_control (
  input  logic                              write_clk,
  input  logic                              rst_n,
  input  logic [`EB_DATA_WIDTH-1:0]         data_in,
  input  logic                              write_enable,
  input  elastic_buffer_pkg::buffer_mode_e  buffer_mode,
  input  logic                              skp_adjust_en,
  input  logic [`EB_ADDR_WIDTH:0]           gray_read_pointer,
  output logic                              mem_write,
  output logic [`EB_ADDR_WIDTH:0]           write_address,
  output logic [`EB_ADDR_WIDTH:0]           gray_write_pointer,
  output logic                              overflow,
  output logic                              skp_removed
);
  import elastic_buffer_pkg::*;

  // read pointer after the two-flop crossing
  logic [`EB_ADDR_WIDTH:0] read_gray_meta;
  logic [`EB_ADDR_WIDTH:0] read_gray_sync;
  logic [`EB_ADDR_WIDTH:0] read_binary_sync;
  logic [`EB_ADDR_WIDTH:0] fill_level;
  logic [`EB_ADDR_WIDTH:0] high_threshold;
  logic [`EB_ADDR_WIDTH:0] write_address_next;
  logic                    full;
  logic                    is_skp;
  logic                    drop_skp;

  // crossing from read_clk, first flop may go metastable
  always_ff @(posedge write_clk or negedge rst_n) begin
    if (!rst_n) begin
      read_gray_meta <= '0;
      read_gray_sync <= '0;
    end else begin
      read_gray_meta <= gray_read_pointer;
      read_gray_sync <= read_gray_meta;
    end
  end

  // level seen from the write side, pessimistic by the sync delay
  assign read_binary_sync = gray_to_bin(read_gray_sync);
  assign fill_level       = write_address - read_binary_sync;

  // full: top two gray bits inverted, lower bits equal
  assign full = (gray_write_pointer[`EB_ADDR_WIDTH:`EB_ADDR_WIDTH-1] ==
                 ~read_gray_sync[`EB_ADDR_WIDTH:`EB_ADDR_WIDTH-1]) &&
                (gray_write_pointer[`EB_ADDR_WIDTH-2:0] ==
                 read_gray_sync[`EB_ADDR_WIDTH-2:0]);

  // removal point depends on the nominal fill
  assign high_threshold = (buffer_mode == HALF_FULL) ?
                          (`EB_ADDR_WIDTH+1)'(`EB_HF_HIGH) :
                          (`EB_ADDR_WIDTH+1)'(`EB_NE_HIGH);

  // either disparity counts as SKP
  assign is_skp = (data_in == `EB_SKP_RDN) || (data_in == `EB_SKP_RDP);

  // full takes priority, the symbol is lost as overflow
  assign drop_skp  = write_enable && !full && is_skp && skp_adjust_en &&
                     (fill_level > high_threshold);
  assign mem_write = write_enable && !full && !drop_skp;

  assign write_address_next = write_address + 1'b1;

  // binary and gray kept in step, gray goes out glitch free
  always_ff @(posedge write_clk or negedge rst_n) begin
    if (!rst_n) begin
      write_address      <= '0;
      gray_write_pointer <= '0;
    end else if (mem_write) begin
      write_address      <= write_address_next;
      gray_write_pointer <= write_address_next ^ (write_address_next >> 1);
    end
  end

  // one cycle event pulses for the counters
  always_ff @(posedge write_clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow    <= 1'b0;
      skp_removed <= 1'b0;
    end else begin
      overflow    <= write_enable && full;
      skp_removed <= drop_skp;
    end
  end

endmodule

/* read_pointer_control.sv */
`timescale 1ns/1ps
`include "elastic_buffer_macros.svh"

module read_pointer_control (
  input  logic                              read_clk,
  input  logic                              rst_n,
  input  logic                              read_enable,
  input  elastic_buffer_pkg::buffer_mode_e  buffer_mode,
  input  logic                              skp_adjust_en,
  input  logic [`EB_ADDR_WIDTH:0]           gray_write_pointer,
  input  logic [`EB_DATA_WIDTH-1:0]         head_symbol,
  output logic [`EB_ADDR_WIDTH:0]           read_address,
  output logic [`EB_ADDR_WIDTH:0]           gray_read_pointer,
  output logic                              mem_read,
  output logic                              data_valid,
  output logic                              underflow,
  output logic                              skp_hold
);
  import elastic_buffer_pkg::*;

  // write pointer after the two-flop crossing
  logic [`EB_ADDR_WIDTH:0] write_gray_meta;
  logic [`EB_ADDR_WIDTH:0] write_gray_sync;
  logic [`EB_ADDR_WIDTH:0] write_binary_sync;
  logic [`EB_ADDR_WIDTH:0] fill_level;
  logic [`EB_ADDR_WIDTH:0] low_threshold;
  logic [`EB_ADDR_WIDTH:0] read_address_next;
  logic                    empty;
  logic                    head_is_skp;

  // crossing from write_clk
  always_ff @(posedge read_clk or negedge rst_n) begin
    if (!rst_n) begin
      write_gray_meta <= '0;
      write_gray_sync <= '0;
    end else begin
      write_gray_meta <= gray_write_pointer;
      write_gray_sync <= write_gray_meta;
    end
  end

  // level seen from the read side, lags new writes by the sync
  assign write_binary_sync = gray_to_bin(write_gray_sync);
  assign fill_level        = write_binary_sync - read_address;

  // empty when gray pointers match exactly
  assign empty = (gray_read_pointer == write_gray_sync);

  // nominal-empty never inserts, a zero threshold is never undercut
  assign low_threshold = (buffer_mode == HALF_FULL) ?
                         (`EB_ADDR_WIDTH+1)'(`EB_HF_LOW) :
                         '0;

  assign head_is_skp = (head_symbol == `EB_SKP_RDN) ||
                       (head_symbol == `EB_SKP_RDP);

  // a read happens every enabled cycle with data present
  assign mem_read = read_enable && !empty;

  // stall on a SKP at the head, the memory reads it again
  assign skp_hold = mem_read && skp_adjust_en && head_is_skp &&
                    (fill_level < low_threshold);

  assign read_address_next = read_address + 1'b1;

  // pointer and its gray copy move together
  always_ff @(posedge read_clk or negedge rst_n) begin
    if (!rst_n) begin
      read_address      <= '0;
      gray_read_pointer <= '0;
    end else if (mem_read && !skp_hold) begin
      read_address      <= read_address_next;
      gray_read_pointer <= read_address_next ^ (read_address_next >> 1);
    end
  end

  // aligned with the registered memory output
  always_ff @(posedge read_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_valid <= 1'b0;
      underflow  <= 1'b0;
    end else begin
      data_valid <= mem_read;
      // read requested with nothing stored
      underflow  <= read_enable && empty;
    end
  end

endmodule

/* elastic_buffer_mem.sv */
`timescale 1ns/1ps
`include "elastic_buffer_macros.svh"

module elastic_buffer_mem (
  input  logic                        write_clk,
  input  logic                        read_clk,
  input  logic                        mem_write,
  input  logic [`EB_ADDR_WIDTH-1:0]   write_address,
  input  logic [`EB_DATA_WIDTH-1:0]   data_in,
  input  logic                        mem_read,
  input  logic [`EB_ADDR_WIDTH-1:0]   read_address,
  output logic [`EB_DATA_WIDTH-1:0]   head_symbol,
  output logic [`EB_DATA_WIDTH-1:0]   data_out
);

  logic [`EB_DATA_WIDTH-1:0] storage [`EB_DEPTH];

  // write port on the recovered clock
  always_ff @(posedge write_clk) begin
    if (mem_write) begin
      storage[write_address] <= data_in;
    end
  end

  // peek at the entry under the read pointer for SKP checks
  assign head_symbol = storage[read_address];

  // registered read, idle cycles fill with SKP
  always_ff @(posedge read_clk) begin
    if (mem_read) begin
      data_out <= storage[read_address];
    end else begin
      data_out <= `EB_SKP_RDN;
    end
  end

endmodule

/* elastic_buffer_regs.sv */
`timescale 1ns/1ps

module elastic_buffer_regs (
  input  logic                              write_clk,
  input  logic                              rst_n,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [7:0]                        paddr,
  input  logic [31:0]                       pwdata,
  input  logic                              overflow,
  input  logic                              skp_removed,
  output logic [31:0]                       prdata,
  output logic                              pready,
  output logic                              pslverr,
  output elastic_buffer_pkg::buffer_mode_e  buffer_mode,
  output logic                              skp_adjust_en
);
  import elastic_buffer_pkg::*;

  reg_addr_e   reg_addr;
  logic        access;
  logic        write_access;
  logic        addr_valid;
  logic        overflow_sticky;
  logic [15:0] skp_removed_count;
  logic [15:0] overflow_count;
  logic [31:0] read_mux;

  // access phase of an APB transfer
  assign access       = psel && penable;
  assign write_access = access && pwrite;
  assign reg_addr     = reg_addr_e'(paddr);

  // no wait states
  assign pready = 1'b1;

  // address decode and read mux
  always_comb begin
    addr_valid = 1'b1;
    read_mux   = '0;
    case (reg_addr)
      REG_CTRL:         read_mux = {30'd0, skp_adjust_en, buffer_mode};
      REG_STATUS:       read_mux = {31'd0, overflow_sticky};
      REG_SKP_REMOVED:  read_mux = {16'd0, skp_removed_count};
      REG_OVERFLOW_CNT: read_mux = {16'd0, overflow_count};
      default:          addr_valid = 1'b0;
    endcase
  end

  assign pslverr = access && !addr_valid;
  // data only while a read is in its access phase
  assign prdata  = (access && !pwrite) ? read_mux : '0;

  // CTRL, bit 0 mode and bit 1 adjust enable
  always_ff @(posedge write_clk or negedge rst_n) begin
    if (!rst_n) begin
      buffer_mode   <= HALF_FULL;
      skp_adjust_en <= 1'b0;
    end else if (write_access && (reg_addr == REG_CTRL)) begin
      buffer_mode   <= buffer_mode_e'(pwdata[0]);
      skp_adjust_en <= pwdata[1];
    end
  end

  // STATUS bit 0, a new overflow wins over the clear
  always_ff @(posedge write_clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow_sticky <= 1'b0;
    end else if (overflow) begin
      overflow_sticky <= 1'b1;
    end else if (write_access && (reg_addr == REG_STATUS) && pwdata[0]) begin
      overflow_sticky <= 1'b0;
    end
  end

  // event counters stop at all ones
  always_ff @(posedge write_clk or negedge rst_n) begin
    if (!rst_n) begin
      skp_removed_count <= '0;
      overflow_count    <= '0;
    end else begin
      if (skp_removed && (skp_removed_count != 16'hFFFF)) begin
        skp_removed_count <= skp_removed_count + 16'd1;
      end
      if (overflow && (overflow_count != 16'hFFFF)) begin
        overflow_count <= overflow_count + 16'd1;
      end
    end
  end

endmodule

/* elastic_buffer.sv */
`timescale 1ns/1ps
`include "elastic_buffer_macros.svh"

module elastic_buffer (
  input  logic                        write_clk,
  input  logic                        read_clk,
  input  logic                        rst_n,
  input  logic [`EB_DATA_WIDTH-1:0]   data_in,
  input  logic                        write_enable,
  input  logic                        read_enable,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [7:0]                  paddr,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic [`EB_DATA_WIDTH-1:0]   data_out,
  output logic                        data_valid,
  output logic                        overflow,
  output logic                        underflow
);
  import elastic_buffer_pkg::*;

  // quasi-static config from the register block
  buffer_mode_e              buffer_mode;
  logic                      skp_adjust_en;
  logic                      skp_removed;
  // pointers in both encodings
  logic [`EB_ADDR_WIDTH:0]   write_address;
  logic [`EB_ADDR_WIDTH:0]   gray_write_pointer;
  logic [`EB_ADDR_WIDTH:0]   read_address;
  logic [`EB_ADDR_WIDTH:0]   gray_read_pointer;
  logic                      mem_write;
  logic                      mem_read;
  logic [`EB_DATA_WIDTH-1:0] head_symbol;

  write_pointer_control i_write_pointer_control (
    .write_clk          (write_clk),
    .rst_n              (rst_n),
    .data_in            (data_in),
    .write_enable       (write_enable),
    .buffer_mode        (buffer_mode),
    .skp_adjust_en      (skp_adjust_en),
    .gray_read_pointer  (gray_read_pointer),
    .mem_write          (mem_write),
    .write_address      (write_address),
    .gray_write_pointer (gray_write_pointer),
    .overflow           (overflow),
    .skp_removed        (skp_removed)
  );

  // held pointer alone makes the memory repeat the SKP
  read_pointer_control i_read_pointer_control (
    .read_clk           (read_clk),
    .rst_n              (rst_n),
    .read_enable        (read_enable),
    .buffer_mode        (buffer_mode),
    .skp_adjust_en      (skp_adjust_en),
    .gray_write_pointer (gray_write_pointer),
    .head_symbol        (head_symbol),
    .read_address       (read_address),
    .gray_read_pointer  (gray_read_pointer),
    .mem_read           (mem_read),
    .data_valid         (data_valid),
    .underflow          (underflow),
    .skp_hold           ()
  );

  // memory indexes with the wrap bit stripped
  elastic_buffer_mem i_elastic_buffer_mem (
    .write_clk     (write_clk),
    .read_clk      (read_clk),
    .mem_write     (mem_write),
    .write_address (write_address[`EB_ADDR_WIDTH-1:0]),
    .data_in       (data_in),
    .mem_read      (mem_read),
    .read_address  (read_address[`EB_ADDR_WIDTH-1:0]),
    .head_symbol   (head_symbol),
    .data_out      (data_out)
  );

  elastic_buffer_regs i_elastic_buffer_regs (
    .write_clk     (write_clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .overflow      (overflow),
    .skp_removed   (skp_removed),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .buffer_mode   (buffer_mode),
    .skp_adjust_en (skp_adjust_en)
  );

endmodule

/* elastic_buffer_props.sv */
`timescale 1ns/1ps
`include "elastic_buffer_macros.svh"

module elastic_buffer_props (
  input logic                      write_clk,
  input logic                      read_clk,
  input logic                      rst_n,
  input logic                      write_enable,
  input logic                      write_full,
  input logic [`EB_ADDR_WIDTH:0]   write_address,
  input logic                      overflow,
  input logic                      psel,
  input logic                      penable,
  input logic [7:0]                paddr,
  input logic                      pslverr,
  input logic                      data_valid,
  input logic                      underflow
);
  import elastic_buffer_pkg::*;

  // failed properties, read back by the testbench at the end
  int unsigned failure_count;
  logic        defined_addr;

  initial failure_count = 0;

  // the four registers of the map
  assign defined_addr = paddr inside {REG_CTRL, REG_STATUS, REG_SKP_REMOVED, REG_OVERFLOW_CNT};

  // overflow pulse one cycle after a write into a full buffer
  overflow_on_full: assert property (@(posedge write_clk) disable iff (!rst_n)
      (write_enable && write_full) |=> overflow)
    else begin
      failure_count++;
      $error("write into a full buffer gave no overflow pulse");
    end

  // and never without one
  overflow_only_on_full: assert property (@(posedge write_clk) disable iff (!rst_n)
      overflow |-> $past(write_enable && write_full))
    else begin
      failure_count++;
      $error("overflow pulsed without a write into a full buffer");
    end

  // pointer frozen while full
  pointer_held_when_full: assert property (@(posedge write_clk) disable iff (!rst_n)
      write_full |=> $stable(write_address))
    else begin
      failure_count++;
      $error("write pointer advanced while the buffer was full");
    end

  // slave error exactly on undefined addresses in the access phase
  slverr_on_undefined: assert property (@(posedge write_clk) disable iff (!rst_n)
      pslverr == (psel && penable && !defined_addr))
    else begin
      failure_count++;
      $error("pslverr does not match the address decode");
    end

  // valid data and underflow exclude each other
  valid_not_underflow: assert property (@(posedge read_clk) disable iff (!rst_n)
      !(data_valid && underflow))
    else begin
      failure_count++;
      $error("data_valid and underflow high in the same cycle");
    end

endmodule

bind elastic_buffer elastic_buffer_props i_elastic_buffer_props (
  .write_clk     (write_clk),
  .read_clk      (read_clk),
  .rst_n         (rst_n),
  .write_enable  (write_enable),
  .write_full    (i_write_pointer_control.full),
  .write_address (write_address),
  .overflow      (overflow),
  .psel          (psel),
  .penable       (penable),
  .paddr         (paddr),
  .pslverr       (pslverr),
  .data_valid    (data_valid),
  .underflow     (underflow)
);

/* tb_elastic_buffer.sv */
`timescale 1ns/1ps
`include "elastic_buffer_macros.svh"

module tb_elastic_buffer;
  import elastic_buffer_pkg::*;

  typedef logic [`EB_DATA_WIDTH-1:0] symbol_t;
  typedef symbol_t symbol_q_t[$];

  localparam int RESET_CYCLES = 8;
  // longest wait for any condition, in clock cycles
  localparam int WAIT_LIMIT   = 2000;

  logic        write_clk;
  logic        read_clk;
  logic        rst_n;
  symbol_t     data_in;
  logic        write_enable;
  logic        read_enable;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  symbol_t     data_out;
  logic        data_valid;
  logic        overflow;
  logic        underflow;

  int unsigned check_count;
  int unsigned error_count;
  int unsigned timeout_count;
  string       test_name;
  // non-SKP symbols still due at the output, oldest first
  symbol_q_t   expected_q;
  logic        overflow_seen;
  logic        underflow_seen;
  logic        valid_seen;

  elastic_buffer i_elastic_buffer (
    .write_clk    (write_clk),
    .read_clk     (read_clk),
    .rst_n        (rst_n),
    .data_in      (data_in),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .data_out     (data_out),
    .data_valid   (data_valid),
    .overflow     (overflow),
    .underflow    (underflow)
  );

  // recovered clock 8 ns, local clock slightly slower
  initial begin
    write_clk = 1'b0;
    forever #4 write_clk = ~write_clk;
  end

  initial begin
    read_clk = 1'b0;
    forever #4.1 read_clk = ~read_clk;
  end

  // event monitors, sampled away from the active edges
  always @(negedge write_clk) begin
    if (overflow) overflow_seen = 1'b1;
  end

  always @(negedge read_clk) begin
    if (underflow) underflow_seen = 1'b1;
    if (data_valid) valid_seen = 1'b1;
  end

  function automatic logic skp_symbol(input symbol_t sym);
    return (sym == `EB_SKP_RDN) || (sym == `EB_SKP_RDP);
  endfunction

  // reference: SKPs may be added or removed, all other symbols pass in order
  function automatic symbol_q_t filter_skp(input symbol_q_t stream);
    symbol_q_t kept;
    foreach (stream[i]) begin
      if (!skp_symbol(stream[i])) kept.push_back(stream[i]);
    end
    return kept;
  endfunction

  function automatic symbol_t random_data();
    symbol_t sym;
    sym = symbol_t'($urandom);
    // move a draw off the SKP codes
    if (skp_symbol(sym)) sym = sym ^ 10'h001;
    return sym;
  endfunction

  // output checker, SKPs dropped before the compare
  initial begin : compare_output
    symbol_t expected;
    forever begin
      @(negedge read_clk);
      if (rst_n && data_valid && !skp_symbol(data_out)) begin
        check_count++;
        assert (expected_q.size() > 0) else begin
          error_count++;
          $display("[%s] symbol %h came out with nothing left to expect", test_name, data_out);
        end
        if (expected_q.size() > 0) begin
          expected = expected_q.pop_front();
          assert (data_out == expected) else begin
            error_count++;
            $display("** Error [%s] data_out expected %h actual %h",
                     test_name, expected, data_out);
          end
        end
      end
    end
  end

  // one APB transfer, setup then access
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int cycles;
    cycles = 0;
    @(negedge write_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge write_clk);
    penable = 1'b1;
    #1;
    while (!pready && cycles < WAIT_LIMIT) begin
      @(negedge write_clk);
      #1;
      cycles++;
    end
    if (!pready) begin
      timeout_count++;
      $display("[%s] timeout, APB access to %h never got pready", test_name, addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge write_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] value);
    logic [31:0] ignored;
    logic        err;
    apb_transfer(1'b1, addr, value, ignored, err);
    assert (!err) else begin
      error_count++;
      $display("[%s] write to register %h was answered with pslverr", test_name, addr);
    end
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] value);
    logic err;
    apb_transfer(1'b0, addr, 32'd0, value, err);
    assert (!err) else begin
      error_count++;
      $display("[%s] read of register %h was answered with pslverr", test_name, addr);
    end
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] value;
    reg_read(addr, value);
    check_count++;
    assert (value == expected) else begin
      error_count++;
      $display("** Error [%s] register %h expected %h actual %h",
               test_name, addr, expected, value);
    end
  endtask

  task automatic send_stream(input symbol_q_t stream);
    foreach (stream[i]) begin
      @(negedge write_clk);
      write_enable = 1'b1;
      data_in      = stream[i];
    end
    @(negedge write_clk);
    write_enable = 1'b0;
  endtask

  task automatic set_read_enable(input logic value);
    @(negedge read_clk);
    read_enable = value;
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(negedge read_clk);
      cycles++;
    end
    if (expected_q.size() != 0) begin
      timeout_count++;
      $display("[%s] timeout, %0d symbols never left the buffer", test_name, expected_q.size());
      expected_q.delete();
    end
  endtask

  task automatic wait_for_underflow();
    int cycles;
    cycles = 0;
    while (!underflow_seen && cycles < WAIT_LIMIT) begin
      @(negedge read_clk);
      cycles++;
    end
    if (!underflow_seen) begin
      timeout_count++;
      $display("[%s] timeout, underflow never pulsed on an empty buffer", test_name);
    end
  endtask

  initial begin : main_sequence
    symbol_q_t   stream;
    logic [31:0] value;
    logic        err;
    int unsigned property_failures;
    void'($urandom(32'h87e6_0125));
    rst_n          = 1'b0;
    data_in        = '0;
    write_enable   = 1'b0;
    read_enable    = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    check_count    = 0;
    error_count    = 0;
    timeout_count  = 0;
    overflow_seen  = 1'b0;
    underflow_seen = 1'b0;
    valid_seen     = 1'b0;
    test_name      = "reset";
    repeat (RESET_CYCLES) @(negedge write_clk);
    rst_n = 1'b1;
    repeat (4) @(negedge write_clk);

    // all registers clear out of reset, hole in the map errors
    test_name = "reset_values";
    check_reg(REG_CTRL, 32'd0);
    check_reg(REG_STATUS, 32'd0);
    check_reg(REG_SKP_REMOVED, 32'd0);
    check_reg(REG_OVERFLOW_CNT, 32'd0);
    apb_transfer(1'b0, 8'h10, 32'd0, value, err);
    check_count++;
    assert (err) else begin
      error_count++;
      $display("[%s] address 10 was accepted without pslverr", test_name);
    end

    // CTRL bit 0 mode, bit 1 adjust
    test_name = "ctrl_access";
    reg_write(REG_CTRL, 32'h3);
    check_reg(REG_CTRL, 32'h3);
    reg_write(REG_CTRL, 32'h2);
    check_reg(REG_CTRL, 32'h2);
    reg_write(REG_STATUS, 32'h1);
    check_reg(REG_STATUS, 32'd0);

    // half-full with adjust, SKP every 8 symbols, reader running
    test_name = "skp_flow";
    stream.delete();
    for (int i = 0; i < 64; i++) begin
      if (i % 16 == 0) stream.push_back(`EB_SKP_RDN);
      else if (i % 8 == 0) stream.push_back(`EB_SKP_RDP);
      else stream.push_back(random_data());
    end
    expected_q = filter_skp(stream);
    set_read_enable(1'b1);
    send_stream(stream);
    wait_for_drain();
    set_read_enable(1'b0);
    repeat (10) @(negedge write_clk);

    // mostly SKPs into a stalled reader, removal keeps it from filling
    test_name = "skp_removal";
    overflow_seen = 1'b0;
    stream.delete();
    for (int i = 0; i < 40; i++) begin
      if (i % 8 == 0) stream.push_back(random_data());
      else if (i % 2 == 0) stream.push_back(`EB_SKP_RDN);
      else stream.push_back(`EB_SKP_RDP);
    end
    expected_q = filter_skp(stream);
    send_stream(stream);
    repeat (4) @(negedge write_clk);
    check_count++;
    assert (!overflow_seen) else begin
      error_count++;
      $display("[%s] overflow pulsed although SKPs should have been removed", test_name);
    end
    reg_read(REG_SKP_REMOVED, value);
    check_count++;
    assert (value >= 1) else begin
      error_count++;
      $display("** Error [%s] REG_SKP_REMOVED expected >= 1 actual %0d", test_name, value);
    end
    // adjust off while the writer is idle, no insertion during the drain
    reg_write(REG_CTRL, 32'h0);
    set_read_enable(1'b1);
    wait_for_drain();
    set_read_enable(1'b0);
    repeat (10) @(negedge write_clk);

    // no removal, the writes beyond the depth are lost
    test_name = "overflow";
    overflow_seen = 1'b0;
    stream.delete();
    for (int i = 0; i < 20; i++) begin
      stream.push_back(random_data());
    end
    for (int i = 0; i < `EB_DEPTH; i++) begin
      expected_q.push_back(stream[i]);
    end
    send_stream(stream);
    repeat (4) @(negedge write_clk);
    check_count++;
    assert (overflow_seen) else begin
      error_count++;
      $display("[%s] overflow never pulsed on writes into a full buffer", test_name);
    end
    check_reg(REG_OVERFLOW_CNT, 32'(20 - `EB_DEPTH));
    check_reg(REG_STATUS, 32'h1);
    reg_write(REG_STATUS, 32'h1);
    check_reg(REG_STATUS, 32'd0);
    set_read_enable(1'b1);
    wait_for_drain();
    set_read_enable(1'b0);
    repeat (10) @(negedge write_clk);

    // reader on an empty buffer
    test_name = "underflow";
    underflow_seen = 1'b0;
    valid_seen     = 1'b0;
    set_read_enable(1'b1);
    wait_for_underflow();
    repeat (20) @(negedge read_clk);
    check_count++;
    assert (!valid_seen) else begin
      error_count++;
      $display("[%s] data_valid went high on an empty buffer", test_name);
    end
    set_read_enable(1'b0);
    repeat (4) @(negedge write_clk);

    property_failures = i_elastic_buffer.i_elastic_buffer_props.failure_count;
    $display("checks %0d, errors %0d, timeouts %0d, property failures %0d",
             check_count, error_count, timeout_count, property_failures);
    if (error_count == 0 && timeout_count == 0 && property_failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // hard stop if the sequence hangs
  initial begin : watchdog
    #500_000;
    $display("watchdog expired before the sequence finished, errors %0d, timeouts %0d",
             error_count, timeout_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* elastic_buffer.f */
+incdir+.
elastic_buffer_pkg.sv
write_pointer_control.sv
read_pointer_control.sv
elastic_buffer_mem.sv
elastic_buffer_regs.sv
elastic_buffer.sv
elastic_buffer_props.sv
tb_elastic_buffer.sv

/* Makefile */
# Verilator build and run of the elastic buffer testbench

VERILATOR       ?= verilator
TOP             ?= tb_elastic_buffer
FILE_LIST       ?= elastic_buffer.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM_FLAGS       ?= +verilator+error+limit+100
PASS_TEXT       ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
